/* files.f */
+incdir+testbench
design/conv_sizes_pkg.sv
design/conv_ctrl_pkg.sv
design/conv_loader.sv
design/conv_sequencer.sv
design/conv_mac.sv
design/result_fifo.sv
design/conv_top.sv
testbench/conv_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal -f files.f --top-module conv_tb

sim:
	verilator --binary --timing -Wno-fatal -f files.f --top-module conv_tb -Mdir obj_dir
	./obj_dir/Vconv_tb | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/conv_tb_ref.svh */
`ifndef CONV_TB_REF_SVH
`define CONV_TB_REF_SVH

typedef sample_t kernel_t [MAX_K][MAX_K];
typedef sample_t image_t  [IMG_ROWS][IMG_COLS];
typedef int      int_queue_t [$];

// Valid window positions for a kernel of side k
function automatic int window_count(input int k);
    return (IMG_ROWS - k + 1) * (IMG_COLS - k + 1);
endfunction

// Expected results in row-major window order
function automatic int_queue_t conv_reference(input int k, input sample_t bias,
                                              input kernel_t kern, input image_t img);
    int_queue_t results;
    int         sum;
    for (int r = 0; r + k <= IMG_ROWS; r++) begin
        for (int c = 0; c + k <= IMG_COLS; c++) begin
            sum = int'(bias);
            for (int i = 0; i < k; i++) begin
                for (int j = 0; j < k; j++) begin
                    sum += int'(img[r + i][c + j]) * int'(kern[i][j]);
                end
            end
            results.push_back(sum);
        end
    end
    return results;
endfunction

task automatic compare_result(input string name, input acc_t got, input acc_t want);
    if (got !== want) begin
        $display("FAIL time=%0t signal=%s got=%0d expected=%0d",
                 $time, name, got, want);
        halt_on_error();
    end
endtask

task automatic compare_count(input string name, input int got, input int want);
    if (got != want) begin
        $display("FAIL time=%0t signal=%s got=%0d expected=%0d",
                 $time, name, got, want);
        halt_on_error();
    end
endtask

`endif

/* testbench/conv_tb.sv */
module conv_tb;
    import conv_sizes_pkg::*;
    import conv_ctrl_pkg::*;

    localparam int FRAMES      = 5;
    localparam int LOAD_BEATS  = MAX_K * MAX_K + 1 + IMG_ROWS * IMG_COLS;
    localparam int MAX_WINDOWS = IMG_ROWS * IMG_COLS;
    localparam int CYCLE_LIMIT = FRAMES * (LOAD_BEATS + MAX_WINDOWS * (MAX_K + 4)) * 4;

    logic     clk;
    logic     reset;
    sample_t  in_data;
    in_user_t in_user;
    logic     in_valid;
    logic     in_ready;
    acc_t     out_data;
    logic     out_valid;
    logic     out_ready;

    acc_t     exp_q[$];
    int       out_count;
    int       full_cycles;

    `include "conv_tb_ref.svh"

    kernel_t  kernel;
    image_t   image;

    conv_top u_conv_top (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_user   (in_user),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    task automatic halt_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_problem(input string reason);
        $display("time %0t: %s", $time, reason);
        halt_on_error();
    endtask

    // Random idle cycles first, then valid held until in_ready
    task automatic send_beat(input sample_t data, input in_user_t user);
        while ($urandom_range(0, 3) == 0) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= data;
        in_user  <= user;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
    endtask

    task automatic fill_data(input int mode);
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_COLS; c++)
                image[r][c] = (mode == 2) ? sample_t'(-128) : sample_t'($urandom);
        end
        for (int i = 0; i < MAX_K; i++) begin
            for (int j = 0; j < MAX_K; j++) begin
                if (mode == 0)
                    kernel[i][j] = (i == 0 && j == 0) ? sample_t'(1) : sample_t'(0);
                else if (mode == 1)
                    kernel[i][j] = sample_t'($urandom);
                else
                    kernel[i][j] = sample_t'(-128);
            end
        end
    endtask

    task automatic run_frame(input int frame, input int k, input sample_t bias);
        int_queue_t want;
        in_user_t   user;
        int         first_out;
        want      = conv_reference(k, bias, kernel, image);
        first_out = out_count;
        foreach (want[i])
            exp_q.push_back(acc_t'(want[i]));
        for (int i = 0; i < k; i++) begin
            for (int j = 0; j < k; j++) begin
                user.start = (i == 0 && j == 0);
                user.k     = ksize_t'(k);
                send_beat(kernel[i][j], user);
            end
        end
        user = '0;
        send_beat(bias, user);
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_COLS; c++)
                send_beat(image[r][c], user);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        if (in_ready)
            report_problem("in_ready still high after the last pixel was accepted");
        // Frame is over once the loader takes beats again
        while (!in_ready)
            @(negedge clk);
        // Every result of this frame leaves the FIFO before the next frame
        while (out_valid)
            @(negedge clk);
        compare_count($sformatf("results of frame %0d", frame), out_count - first_out,
                      window_count(k));
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : drive_out_ready
        int stall_left;
        stall_left = 0;
        forever begin
            @(posedge clk);
            if (stall_left > 0) begin
                out_ready <= 1'b0;
                stall_left = stall_left - 1;
            end else if ($urandom_range(0, 95) == 0) begin
                out_ready <= 1'b0;
                stall_left = $urandom_range(60, 100);
            end else begin
                out_ready <= 1'($urandom_range(0, 1));
            end
        end
    end

    initial begin : compare_outputs
        acc_t want;
        forever begin
            @(negedge clk);
            if (!reset && !u_conv_top.room)
                full_cycles++;
            if (!reset && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    report_problem("output handshake with no result expected");
                end else begin
                    want = exp_q.pop_front();
                    out_count++;
                    compare_result("out_data", out_data, want);
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT)
                report_problem($sformatf("timeout, run did not finish in %0d cycles", cycles));
        end
    end

    initial begin : main_flow
        int k_shift;
        reset     = 1'b1;
        in_data   = '0;
        in_user   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        void'($urandom(38440));
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (!in_ready || out_valid)
            report_problem("in_ready low or out_valid high after reset");

        // Unit kernel passes the image through
        fill_data(0);
        run_frame(0, 1, sample_t'(0));

        // Three frames back to back, each with its own K
        k_shift = $urandom_range(0, 2);
        for (int f = 1; f <= 3; f++) begin
            fill_data(1);
            run_frame(f, 2 + (k_shift + f) % 3, sample_t'($urandom));
        end

        // Largest kernel with every value at the negative extreme
        fill_data(2);
        run_frame(4, MAX_K, sample_t'(-128));

        repeat (4 * MAX_K) begin
            @(negedge clk);
            if (out_valid)
                report_problem("out_valid high after the last expected result");
        end

        if (full_cycles == 0) begin
            report_problem("output FIFO never filled under back-pressure");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* design/conv_top.sv */
module conv_top (
    input  logic                    clk,
    input  logic                    reset,
    input  conv_sizes_pkg::sample_t in_data,
    input  conv_ctrl_pkg::in_user_t in_user,
    input  logic                    in_valid,
    output logic                    in_ready,
    output conv_sizes_pkg::acc_t    out_data,
    output logic                    out_valid,
    input  logic                    out_ready
);
    import conv_sizes_pkg::*;
    import conv_ctrl_pkg::*;

    ksize_t                k;
    sample_t               bias;
    logic                  loaded;
    read_req_t             rd;
    sample_t [LANES-1:0]   pix_rd;
    sample_t [LANES-1:0]   wgt_rd;
    mac_ctrl_t             ctrl;
    logic                  frame_done;
    logic                  push;
    logic                  room;
    acc_t                  result;

    conv_loader u_conv_loader (
        .clk        (clk),
        .reset      (reset),
        .in_data    (in_data),
        .in_user    (in_user),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .rd         (rd),
        .frame_done (frame_done),
        .k          (k),
        .bias       (bias),
        .loaded     (loaded),
        .pix_rd     (pix_rd),
        .wgt_rd     (wgt_rd)
    );

    conv_sequencer u_conv_sequencer (
        .clk        (clk),
        .reset      (reset),
        .k          (k),
        .loaded     (loaded),
        .room       (room),
        .rd         (rd),
        .ctrl       (ctrl),
        .push       (push),
        .frame_done (frame_done)
    );

    conv_mac u_conv_mac (
        .clk    (clk),
        .reset  (reset),
        .pix_rd (pix_rd),
        .wgt_rd (wgt_rd),
        .ctrl   (ctrl),
        .bias   (bias),
        .result (result)
    );

    result_fifo u_result_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_data  (result),
        .wr_valid (push),
        .room     (room),
        .rd_data  (out_data),
        .rd_valid (out_valid),
        .rd_ready (out_ready)
    );

endmodule

/* design/result_fifo.sv */
module result_fifo (
    input  logic                 clk,
    input  logic                 reset,
    input  conv_sizes_pkg::acc_t wr_data,
    input  logic                 wr_valid,
    output logic                 room,
    output conv_sizes_pkg::acc_t rd_data,
    output logic                 rd_valid,
    input  logic                 rd_ready
);
    import conv_sizes_pkg::*;

    acc_t                            mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;
    logic                            do_wr;
    logic                            do_rd;

    assign room     = (count != FIFO_DEPTH);
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign do_wr    = wr_valid && room;
    assign do_rd    = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    // Power-of-two depth, pointers wrap naturally
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/conv_mac.sv */
module conv_mac (
    input  logic                                                clk,
    input  logic                                                reset,
    input  conv_sizes_pkg::sample_t [conv_sizes_pkg::LANES-1:0] pix_rd,
    input  conv_sizes_pkg::sample_t [conv_sizes_pkg::LANES-1:0] wgt_rd,
    input  conv_ctrl_pkg::mac_ctrl_t                           ctrl,
    input  conv_sizes_pkg::sample_t                             bias,
    output conv_sizes_pkg::acc_t                                result
);
    import conv_sizes_pkg::*;
    import conv_ctrl_pkg::*;

    product_t  [LANES-1:0]   prod;
    mac_ctrl_t [MAC_LAT-1:0] ctrl_pipe;
    mac_ctrl_t               ctrl_d;
    acc_t                    lane_sum;

    // Multiply stage, one signed product per lane
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++)
            prod[l] <= pix_rd[l] * wgt_rd[l];
    end

    // Control follows the read and multiply stages
    always_ff @(posedge clk) begin
        if (reset)
            ctrl_pipe <= '0;
        else
            ctrl_pipe <= {ctrl_pipe[MAC_LAT-2:0], ctrl};
    end

    assign ctrl_d = ctrl_pipe[MAC_LAT-1];

    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < LANES; l++) begin
            if (ctrl_d.mask[l])
                lane_sum = lane_sum + acc_t'(prod[l]);
        end
    end

    // A new window starts from the bias
    always_ff @(posedge clk) begin
        if (ctrl_d.first)
            result <= acc_t'(bias) + lane_sum;
        else if (ctrl_d.valid)
            result <= result + lane_sum;
    end

endmodule

/* design/conv_sequencer.sv */
module conv_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  conv_sizes_pkg::ksize_t   k,
    input  logic                     loaded,
    input  logic                     room,
    output conv_ctrl_pkg::read_req_t rd,
    output conv_ctrl_pkg::mac_ctrl_t ctrl,
    output logic                     push,
    output logic                     frame_done
);
    import conv_sizes_pkg::*;
    import conv_ctrl_pkg::*;

    seq_state_t state;
    pix_addr_t  row;
    pix_addr_t  col;
    pix_addr_t  row_end;
    pix_addr_t  col_end;
    ksize_t     krow;
    ksize_t     drain;
    logic       last_row;
    logic       last_col;

    // Last valid window position along each axis
    assign row_end  = pix_addr_t'(IMG_ROWS) - pix_addr_t'(k);
    assign col_end  = pix_addr_t'(IMG_COLS) - pix_addr_t'(k);
    assign last_row = (row == row_end);
    assign last_col = (col == col_end);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LOAD_WAIT;
            row   <= '0;
            col   <= '0;
            krow  <= '0;
            drain <= '0;
        end else begin
            case (state)
                LOAD_WAIT: begin
                    row   <= '0;
                    col   <= '0;
                    krow  <= '0;
                    drain <= '0;
                    if (loaded)
                        state <= COMPUTE;
                end
                COMPUTE: begin
                    if (krow == k - ksize_t'(1)) begin
                        krow  <= '0;
                        drain <= '0;
                        state <= DRAIN;
                    end else begin
                        krow <= krow + ksize_t'(1);
                    end
                end
                DRAIN: begin
                    if (drain == ksize_t'(MAC_LAT - 1))
                        state <= WRITE;
                    else
                        drain <= drain + ksize_t'(1);
                end
                WRITE: if (room) begin
                    if (last_col) begin
                        col <= '0;
                        row <= row + pix_addr_t'(1);
                    end else begin
                        col <= col + pix_addr_t'(1);
                    end
                    state <= (last_row && last_col) ? LOAD_WAIT : COMPUTE;
                end
                default: state <= LOAD_WAIT;
            endcase
        end
    end

    // Row base of the current kernel row inside the current window
    always_comb begin
        rd.pix_base = (row + pix_addr_t'(krow)) * pix_addr_t'(IMG_COLS) + col;
        rd.wgt_base = wgt_addr_t'(krow) * wgt_addr_t'(k);
    end

    always_comb begin
        ctrl.valid = (state == COMPUTE);
        ctrl.first = (state == COMPUTE) && (krow == '0);
        for (int l = 0; l < LANES; l++)
            ctrl.mask[l] = ctrl.valid && (ksize_t'(l) < k);
    end

    assign push       = (state == WRITE);
    assign frame_done = (state == WRITE) && room && last_row && last_col;

endmodule

/* design/conv_loader.sv */
module conv_loader (
    input  logic                                       clk,
    input  logic                                       reset,
    input  conv_sizes_pkg::sample_t                    in_data,
    input  conv_ctrl_pkg::in_user_t                    in_user,
    input  logic                                       in_valid,
    output logic                                       in_ready,
    input  conv_ctrl_pkg::read_req_t                   rd,
    input  logic                                       frame_done,
    output conv_sizes_pkg::ksize_t                     k,
    output conv_sizes_pkg::sample_t                    bias,
    output logic                                       loaded,
    output conv_sizes_pkg::sample_t [conv_sizes_pkg::LANES-1:0] pix_rd,
    output conv_sizes_pkg::sample_t [conv_sizes_pkg::LANES-1:0] wgt_rd
);
    import conv_sizes_pkg::*;
    import conv_ctrl_pkg::*;

    typedef enum logic [1:0] {
        LD_WEIGHTS,
        LD_BIAS,
        LD_PIXELS,
        LD_FULL
    } load_phase_t;

    load_phase_t phase;
    pix_addr_t   cnt;
    sample_t     pix_mem [IMG_ROWS*IMG_COLS];
    sample_t     wgt_mem [MAX_K*MAX_K];
    logic        take;
    ksize_t      k_eff;
    wgt_addr_t   w_idx;
    logic        w_last;

    assign in_ready = (phase != LD_FULL);
    assign loaded   = (phase == LD_FULL);
    assign take     = in_valid && in_ready;

    // The start beat carries its own k and always lands on weight 0
    always_comb begin
        k_eff  = in_user.start ? in_user.k : k;
        w_idx  = in_user.start ? '0 : wgt_addr_t'(cnt);
        w_last = (w_idx == wgt_addr_t'(k_eff) * wgt_addr_t'(k_eff) - wgt_addr_t'(1));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= LD_WEIGHTS;
            cnt   <= '0;
            k     <= '0;
        end else begin
            case (phase)
                LD_WEIGHTS: if (take) begin
                    if (in_user.start)
                        k <= in_user.k;
                    if (w_last) begin
                        cnt   <= '0;
                        phase <= LD_BIAS;
                    end else begin
                        cnt <= pix_addr_t'(w_idx) + pix_addr_t'(1);
                    end
                end
                LD_BIAS: if (take) begin
                    phase <= LD_PIXELS;
                end
                LD_PIXELS: if (take) begin
                    if (cnt == pix_addr_t'(IMG_ROWS * IMG_COLS - 1)) begin
                        cnt   <= '0;
                        phase <= LD_FULL;
                    end else begin
                        cnt <= cnt + pix_addr_t'(1);
                    end
                end
                LD_FULL: if (frame_done) begin
                    phase <= LD_WEIGHTS;
                end
                default: phase <= LD_WEIGHTS;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take && phase == LD_WEIGHTS)
            wgt_mem[w_idx] <= in_data;
        if (take && phase == LD_BIAS)
            bias <= in_data;
        if (take && phase == LD_PIXELS)
            pix_mem[cnt] <= in_data;
    end

    // Registered row reads, lanes past the end of an array give zero
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (int'(rd.pix_base) + l < IMG_ROWS * IMG_COLS)
                pix_rd[l] <= pix_mem[pix_addr_t'(int'(rd.pix_base) + l)];
            else
                pix_rd[l] <= '0;
            if (int'(rd.wgt_base) + l < MAX_K * MAX_K)
                wgt_rd[l] <= wgt_mem[wgt_addr_t'(int'(rd.wgt_base) + l)];
            else
                wgt_rd[l] <= '0;
        end
    end

endmodule

/* design/conv_ctrl_pkg.sv */
package conv_ctrl_pkg;

    typedef enum logic [1:0] {
        LOAD_WAIT,
        COMPUTE,
        DRAIN,
        WRITE
    } seq_state_t;

    // Sideband of the input stream, k is only looked at on the start beat
    typedef struct packed {
        logic                   start;
        conv_sizes_pkg::ksize_t k;
    } in_user_t;

    // Start of one kernel row in the image and in the kernel
    typedef struct packed {
        conv_sizes_pkg::pix_addr_t pix_base;
        conv_sizes_pkg::wgt_addr_t wgt_base;
    } read_req_t;

    typedef struct packed {
        logic                       valid;
        logic                       first;
        conv_sizes_pkg::lane_mask_t mask;
    } mac_ctrl_t;

endpackage

/* design/conv_sizes_pkg.sv */
package conv_sizes_pkg;

    // Image and kernel geometry
    localparam int IMG_ROWS = 8;
    localparam int IMG_COLS = 8;
    localparam int MAX_K    = 4;

    // One kernel row is read per cycle
    localparam int LANES = MAX_K;

    localparam int DATA_W = 8;

    // Registered read plus registered multiply
    localparam int MAC_LAT = 2;

    // Full-range products of a largest kernel plus the bias
    localparam int ACC_W = 2 * DATA_W + $clog2(MAX_K * MAX_K) + 1;

    localparam int PIX_ADDR_W = $clog2(IMG_ROWS * IMG_COLS);
    localparam int WGT_ADDR_W = $clog2(MAX_K * MAX_K);
    localparam int K_W        = $clog2(MAX_K + 1);

    localparam int FIFO_DEPTH = IMG_COLS;

    typedef logic signed [DATA_W-1:0]   sample_t;
    typedef logic signed [2*DATA_W-1:0] product_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    typedef logic [K_W-1:0]        ksize_t;
    typedef logic [PIX_ADDR_W-1:0] pix_addr_t;
    typedef logic [WGT_ADDR_W-1:0] wgt_addr_t;

    // One bit per multiplier lane
    typedef logic [LANES-1:0] lane_mask_t;

endpackage
